// File: include/mips_mem_wb_defs.svh
// Widths, memory size, command op codes and load kinds for the memory and writeback slice.
// Include wherever one of these macros is used.
`ifndef MIPS_MEM_WB_DEFS_SVH
`define MIPS_MEM_WB_DEFS_SVH

`define MIPS_WORD_W    32
`define MIPS_MEM_WORDS 256
`define MIPS_MEM_WAIT  1

// command op codes
`define OP_ALU  4'd0
`define OP_LW   4'd1
`define OP_LB   4'd2
`define OP_LBU  4'd3
`define OP_LH   4'd4
`define OP_LHU  4'd5
`define OP_SW   4'd6
`define OP_SB   4'd7
`define OP_SH   4'd8
`define OP_LINK 4'd9
`define OP_MFHI 4'd10
`define OP_MFLO 4'd11
`define OP_MTHI 4'd12
`define OP_MTLO 4'd13

// load kinds seen by the writedata selector
`define LD_NONE 3'd0
`define LD_LW   3'd1
`define LD_LB   3'd2
`define LD_LBU  3'd3
`define LD_LH   3'd4
`define LD_LHU  3'd5

`endif

// File: mips_mem_wb.f
+incdir+include
source/mips_mem_wb_pkg.sv
source/apb_if.sv
source/load_store_unit.sv
source/data_memory.sv
source/reg_writedata_selector.sv
source/reg_file.sv
source/mem_wb_ctrl.sv
source/mips_mem_wb.sv
verif/mips_mem_wb_asserts.sv
verif/tb_mips_mem_wb.sv

// File: source/apb_if.sv
// APB bus between the load/store unit and the data memory.
// The master modport drives the request, the slave modport answers it.
`timescale 1ns/1ps
`default_nettype none

interface apb_if;
    import mips_mem_wb_pkg::*;

    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
    strb_t pstrb;
    word_t prdata;
    logic  pready;
    logic  pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata, pstrb,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata, pstrb,
        output prdata, pready, pslverr
    );

endinterface

`default_nettype wire

// File: source/data_memory.sv
// APB slave word memory. Each access waits a fixed number of cycles,
// writes go under pstrb, and a strobe pattern that is not an aligned
// byte, halfword or word is refused with pslverr and no write.
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_wb_defs.svh"

module data_memory (
    input  logic  clk,
    input  logic  rst_n,
    apb_if.slave  apb
);
    import mips_mem_wb_pkg::*;

    localparam int IDX_W = $clog2(`MIPS_MEM_WORDS);

    word_t             mem [`MIPS_MEM_WORDS];
    logic [3:0]        wait_cnt;
    logic [IDX_W-1:0]  idx;
    logic              strb_ok;

    assign idx = apb.paddr[IDX_W+1:2];

    always_comb begin
        case (apb.pstrb)
            4'b0001, 4'b0010, 4'b0100, 4'b1000,
            4'b0011, 4'b1100, 4'b1111: strb_ok = 1'b1;
            default:                   strb_ok = 1'b0;
        endcase
    end

    assign apb.pready  = apb.psel && apb.penable && (wait_cnt == 4'(`MIPS_MEM_WAIT));
    assign apb.pslverr = apb.pready && !strb_ok;
    assign apb.prdata  = mem[idx];

    // wait cycles counted in the access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (apb.psel && apb.penable && !apb.pready) begin
            wait_cnt <= wait_cnt + 4'd1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `MIPS_MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (apb.pready && apb.pwrite && strb_ok) begin
            for (int b = 0; b < 4; b++) begin
                if (apb.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= apb.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/load_store_unit.sv
// APB master of the memory stage. A req pulse starts one transfer on the
// word-aligned address, and ack pulses one cycle after pready with rdata and err.
// size is log2 of the access width in bytes: 0 byte, 1 halfword, 2 word.
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  logic                   write,
    input  logic [1:0]             size,
    input  mips_mem_wb_pkg::addr_t addr,
    input  mips_mem_wb_pkg::word_t wdata,
    output logic                   ack,
    output logic                   err,
    output mips_mem_wb_pkg::word_t rdata,
    apb_if.master                  apb
);
    import mips_mem_wb_pkg::*;

    lsu_state_t state;
    strb_t      base_strb;
    logic [7:0] wide_strb;
    strb_t      lane_strb;
    word_t      lane_wdata;

    // lanes touched by the access, shifted to the byte offset
    always_comb begin
        case (size)
            2'd0:    base_strb = 4'b0001;
            2'd1:    base_strb = 4'b0011;
            default: base_strb = 4'b1111;
        endcase
        wide_strb = {4'b0000, base_strb} << addr[1:0];
        // access crossing the word gets no lanes, so the memory refuses it
        lane_strb = (wide_strb[7:4] != 4'b0000) ? 4'b0000 : wide_strb[3:0];
    end

    // replicate small stores over all lanes
    always_comb begin
        case (size)
            2'd0:    lane_wdata = {4{wdata[7:0]}};
            2'd1:    lane_wdata = {2{wdata[15:0]}};
            default: lane_wdata = wdata;
        endcase
    end

    assign apb.psel    = (state != LSU_IDLE);
    assign apb.penable = (state == LSU_ACCESS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LSU_IDLE;
            ack   <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                LSU_IDLE: begin
                    if (req) begin
                        state <= LSU_SETUP;
                    end
                end
                LSU_SETUP: begin
                    state <= LSU_ACCESS;
                end
                LSU_ACCESS: begin
                    if (apb.pready) begin
                        state <= LSU_IDLE;
                        ack   <= 1'b1;
                    end
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    // request held from setup until pready, response captured with it
    always_ff @(posedge clk) begin
        if (state == LSU_IDLE && req) begin
            apb.pwrite <= write;
            apb.paddr  <= {addr[31:2], 2'b00};
            apb.pwdata <= lane_wdata;
            apb.pstrb  <= lane_strb;
        end
        if (state == LSU_ACCESS && apb.pready) begin
            rdata <= apb.prdata;
            err   <= apb.pslverr;
        end
    end

endmodule

`default_nettype wire

// File: source/mem_wb_ctrl.sv
// Takes one command at a time, starts the load/store unit for memory ops
// and completes with a done pulse and the register write.
// Holds the hi and lo registers written by mthi and mtlo.
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_wb_defs.svh"

module mem_wb_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  mips_mem_wb_pkg::op_t        cmd_op,
    input  mips_mem_wb_pkg::reg_addr_t  cmd_rd,
    input  mips_mem_wb_pkg::addr_t      cmd_addr,
    input  mips_mem_wb_pkg::word_t      cmd_alu_out,
    input  mips_mem_wb_pkg::word_t      cmd_store_data,
    input  mips_mem_wb_pkg::word_t      cmd_pc_plus4,
    output logic                        done,
    output logic                        err,
    output logic                        wb_we,
    output mips_mem_wb_pkg::reg_addr_t  wb_addr,
    output mips_mem_wb_pkg::word_t      wb_data,
    output logic                        lsu_req,
    output logic                        lsu_write,
    output logic [1:0]                  lsu_size,
    output mips_mem_wb_pkg::addr_t      lsu_addr,
    output mips_mem_wb_pkg::word_t      lsu_wdata,
    input  logic                        lsu_ack,
    input  logic                        lsu_err,
    output mips_mem_wb_pkg::load_kind_t load_kind,
    output mips_mem_wb_pkg::byte_sel_t  byte_addressing,
    output logic                        link_to_reg,
    output logic                        mfhi,
    output logic                        mflo,
    output mips_mem_wb_pkg::word_t      alu_out,
    output mips_mem_wb_pkg::word_t      pc_plus4,
    output mips_mem_wb_pkg::word_t      hi_readdata,
    output mips_mem_wb_pkg::word_t      lo_readdata,
    input  mips_mem_wb_pkg::word_t      sel_data
);
    import mips_mem_wb_pkg::*;

    logic      busy;
    logic      lsu_req_q;
    op_t       op_q;
    reg_addr_t rd_q;
    addr_t     addr_q;
    word_t     alu_q;
    word_t     store_q;
    word_t     pc_q;
    word_t     hi_q;
    word_t     lo_q;
    logic      is_mem;
    logic      no_write;

    function automatic logic is_mem_op(op_t op);
        return (op >= `OP_LW) && (op <= `OP_SH);
    endfunction

    assign is_mem   = is_mem_op(op_q);
    assign no_write = op_q inside {`OP_SW, `OP_SB, `OP_SH, `OP_MTHI, `OP_MTLO};

    assign cmd_ready = !busy;
    // memory ops finish on the LSU ack, the others right away
    assign done      = busy && (!is_mem || lsu_ack);
    assign err       = busy && is_mem && lsu_ack && lsu_err;
    assign wb_we     = done && !no_write && !err;
    assign wb_addr   = rd_q;
    assign wb_data   = sel_data;

    assign lsu_req   = lsu_req_q;
    assign lsu_write = op_q inside {`OP_SW, `OP_SB, `OP_SH};
    assign lsu_addr  = addr_q;
    assign lsu_wdata = store_q;

    always_comb begin
        case (op_q)
            `OP_LB, `OP_LBU, `OP_SB: lsu_size = 2'd0;
            `OP_LH, `OP_LHU, `OP_SH: lsu_size = 2'd1;
            default:                 lsu_size = 2'd2;
        endcase
        case (op_q)
            `OP_LW:  load_kind = `LD_LW;
            `OP_LB:  load_kind = `LD_LB;
            `OP_LBU: load_kind = `LD_LBU;
            `OP_LH:  load_kind = `LD_LH;
            `OP_LHU: load_kind = `LD_LHU;
            default: load_kind = `LD_NONE;
        endcase
    end

    assign byte_addressing = addr_q[1:0];
    assign link_to_reg     = (op_q == `OP_LINK);
    assign mfhi            = (op_q == `OP_MFHI);
    assign mflo            = (op_q == `OP_MFLO);
    assign alu_out         = alu_q;
    assign pc_plus4        = pc_q;
    assign hi_readdata     = hi_q;
    assign lo_readdata     = lo_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            lsu_req_q <= 1'b0;
            hi_q      <= '0;
            lo_q      <= '0;
        end else begin
            lsu_req_q <= 1'b0;
            if (cmd_valid && cmd_ready) begin
                busy      <= 1'b1;
                // one request cycle right after acceptance
                lsu_req_q <= is_mem_op(cmd_op);
            end else if (done) begin
                busy <= 1'b0;
                if (op_q == `OP_MTHI) begin
                    hi_q <= alu_q;
                end
                if (op_q == `OP_MTLO) begin
                    lo_q <= alu_q;
                end
            end
        end
    end

    // accepted command
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            op_q    <= cmd_op;
            rd_q    <= cmd_rd;
            addr_q  <= cmd_addr;
            alu_q   <= cmd_alu_out;
            store_q <= cmd_store_data;
            pc_q    <= cmd_pc_plus4;
        end
    end

endmodule

`default_nettype wire

// File: source/mips_mem_wb.sv
// Memory and writeback slice top. Commands come in on a valid/ready pair,
// completion goes out as a done pulse with the register write,
// and the register file can be read through rd_addr and rd_data.
`timescale 1ns/1ps
`default_nettype none

module mips_mem_wb (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  mips_mem_wb_pkg::op_t       cmd_op,
    input  mips_mem_wb_pkg::reg_addr_t cmd_rd,
    input  mips_mem_wb_pkg::addr_t     cmd_addr,
    input  mips_mem_wb_pkg::word_t     cmd_alu_out,
    input  mips_mem_wb_pkg::word_t     cmd_store_data,
    input  mips_mem_wb_pkg::word_t     cmd_pc_plus4,
    output logic                       done,
    output logic                       err,
    output logic                       wb_we,
    output mips_mem_wb_pkg::reg_addr_t wb_addr,
    output mips_mem_wb_pkg::word_t     wb_data,
    input  mips_mem_wb_pkg::reg_addr_t rd_addr,
    output mips_mem_wb_pkg::word_t     rd_data
);
    import mips_mem_wb_pkg::*;

    logic       lsu_req;
    logic       lsu_write;
    logic [1:0] lsu_size;
    addr_t      lsu_addr;
    word_t      lsu_wdata;
    logic       lsu_ack;
    logic       lsu_err;
    word_t      lsu_rdata;
    load_kind_t load_kind;
    byte_sel_t  byte_addressing;
    logic       link_to_reg;
    logic       mfhi;
    logic       mflo;
    word_t      alu_out;
    word_t      pc_plus4;
    word_t      hi_readdata;
    word_t      lo_readdata;
    word_t      sel_data;

    apb_if apb ();

    mem_wb_ctrl mem_wb_ctrl_inst (
        .clk, .rst_n, .cmd_valid, .cmd_ready, .cmd_op, .cmd_rd, .cmd_addr,
        .cmd_alu_out, .cmd_store_data, .cmd_pc_plus4,
        .done, .err, .wb_we, .wb_addr, .wb_data,
        .lsu_req, .lsu_write, .lsu_size, .lsu_addr, .lsu_wdata, .lsu_ack, .lsu_err,
        .load_kind, .byte_addressing, .link_to_reg, .mfhi, .mflo,
        .alu_out, .pc_plus4, .hi_readdata, .lo_readdata, .sel_data
    );

    load_store_unit load_store_unit_inst (
        .clk, .rst_n,
        .req   (lsu_req),
        .write (lsu_write),
        .size  (lsu_size),
        .addr  (lsu_addr),
        .wdata (lsu_wdata),
        .ack   (lsu_ack),
        .err   (lsu_err),
        .rdata (lsu_rdata),
        .apb   (apb.master)
    );

    data_memory data_memory_inst (
        .clk, .rst_n,
        .apb (apb.slave)
    );

    reg_writedata_selector reg_writedata_selector_inst (
        .alu_out, .pc_plus4, .hi_readdata, .lo_readdata,
        .data_readdata  (lsu_rdata),
        .datamem_to_reg (load_kind),
        .byte_addressing, .link_to_reg, .mfhi, .mflo,
        .reg_write_data (sel_data)
    );

    reg_file reg_file_inst (
        .clk, .rst_n,
        .we    (wb_we),
        .waddr (wb_addr),
        .wdata (wb_data),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

`default_nettype wire

// File: source/mips_mem_wb_pkg.sv
// Shared types of the memory and writeback slice.
// Ports name them by scope, module bodies import the package.
`default_nettype none

`include "mips_mem_wb_defs.svh"

package mips_mem_wb_pkg;

    typedef logic [`MIPS_WORD_W-1:0]   word_t;
    typedef logic [31:0]               addr_t;
    typedef logic [4:0]                reg_addr_t;
    typedef logic [3:0]                op_t;
    typedef logic [2:0]                load_kind_t;
    typedef logic [1:0]                byte_sel_t;
    typedef logic [`MIPS_WORD_W/8-1:0] strb_t;

    // APB sequencer of the load/store unit
    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_SETUP,
        LSU_ACCESS
    } lsu_state_t;

endpackage

`default_nettype wire

// File: source/reg_file.sv
// 32-entry general register file with one write port and one
// combinational read port. Register 0 always reads zero.
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       we,
    input  mips_mem_wb_pkg::reg_addr_t waddr,
    input  mips_mem_wb_pkg::word_t     wdata,
    input  mips_mem_wb_pkg::reg_addr_t raddr,
    output mips_mem_wb_pkg::word_t     rdata
);
    import mips_mem_wb_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata = regs[raddr];

endmodule

`default_nettype wire

// File: source/reg_writedata_selector.sv
// Picks the word written to the destination register: loaded data,
// link address, hi, lo or the ALU result, in that priority.
// Byte and halfword loads are extended from the addressed lane.
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_wb_defs.svh"

module reg_writedata_selector (
    input  mips_mem_wb_pkg::word_t      alu_out,
    input  mips_mem_wb_pkg::word_t      data_readdata,
    input  mips_mem_wb_pkg::word_t      pc_plus4,
    input  mips_mem_wb_pkg::word_t      hi_readdata,
    input  mips_mem_wb_pkg::word_t      lo_readdata,
    input  mips_mem_wb_pkg::load_kind_t datamem_to_reg,
    input  mips_mem_wb_pkg::byte_sel_t  byte_addressing,
    input  logic                        link_to_reg,
    input  logic                        mfhi,
    input  logic                        mflo,
    output mips_mem_wb_pkg::word_t      reg_write_data
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    logic        half_ok;

    always_comb begin
        case (byte_addressing)
            2'b00:   lane_byte = data_readdata[7:0];
            2'b01:   lane_byte = data_readdata[15:8];
            2'b10:   lane_byte = data_readdata[23:16];
            default: lane_byte = data_readdata[31:24];
        endcase
    end

    assign lane_half = byte_addressing[1] ? data_readdata[31:16] : data_readdata[15:0];
    // halfwords only at offsets 0 and 2
    assign half_ok   = !byte_addressing[0];

    always_comb begin
        case (datamem_to_reg)
            `LD_LW:  reg_write_data = data_readdata;
            `LD_LB:  reg_write_data = {{24{lane_byte[7]}}, lane_byte};
            `LD_LBU: reg_write_data = {24'h000000, lane_byte};
            `LD_LH:  reg_write_data = half_ok ? {{16{lane_half[15]}}, lane_half} : '0;
            `LD_LHU: reg_write_data = half_ok ? {16'h0000, lane_half} : '0;
            default: begin
                // link writes the address past the delay slot
                if (link_to_reg) begin
                    reg_write_data = pc_plus4 + 32'd4;
                end else if (mfhi) begin
                    reg_write_data = hi_readdata;
                end else if (mflo) begin
                    reg_write_data = lo_readdata;
                end else begin
                    reg_write_data = alu_out;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verif/mips_mem_wb_asserts.sv
// Concurrent checks on the APB master side of the load/store unit.
// Bound into every load_store_unit instance.
`timescale 1ns/1ps
`default_nettype none

module mips_mem_wb_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   psel,
    input logic                   penable,
    input logic                   pwrite,
    input mips_mem_wb_pkg::addr_t paddr,
    input mips_mem_wb_pkg::word_t pwdata,
    input mips_mem_wb_pkg::strb_t pstrb,
    input logic                   pready,
    input logic                   ack
);
    int fail_count = 0;

    // a transfer opens with exactly one setup cycle
    setup_then_access: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(psel) |-> !penable ##1 penable)
        else begin
            $error("penable did not follow a single psel setup cycle");
            fail_count++;
        end

    // request held until the slave answers
    request_stable: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !pready |=> psel && $stable(pwrite) && $stable(paddr)
            && $stable(pwdata) && $stable(pstrb))
        else begin
            $error("APB request changed before pready");
            fail_count++;
        end

    no_ack_in_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        !(ack && psel))
        else begin
            $error("ack high while psel is still high");
            fail_count++;
        end

endmodule

bind load_store_unit mips_mem_wb_asserts apb_checks_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (apb.psel),
    .penable (apb.penable),
    .pwrite  (apb.pwrite),
    .paddr   (apb.paddr),
    .pwdata  (apb.pwdata),
    .pstrb   (apb.pstrb),
    .pready  (apb.pready),
    .ack     (ack)
);

`default_nettype wire

// File: verif/tb_mips_mem_wb.sv
// Testbench for the memory and writeback slice. Drives commands on the
// valid/ready port, checks every done pulse against a reference model
// and reads registers back through the read port.
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_wb_defs.svh"

module tb_mips_mem_wb;
    import mips_mem_wb_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int IDX_W        = $clog2(`MIPS_MEM_WORDS);
    // commands and register reads issued by the stimulus below
    localparam int N_CMDS       = 100;
    localparam int N_READS      = 8;
    localparam int TIMEOUT_NS   = ((N_CMDS + N_READS) * 20 + RESET_CYCLES) * CLK_PERIOD;

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    logic      cmd_ready;
    op_t       cmd_op;
    reg_addr_t cmd_rd;
    addr_t     cmd_addr;
    word_t     cmd_alu_out;
    word_t     cmd_store_data;
    word_t     cmd_pc_plus4;
    logic      done;
    logic      err;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    reg_addr_t rd_addr;
    word_t     rd_data;

    // reference state
    word_t model_mem [`MIPS_MEM_WORDS];
    word_t model_regs [32];
    word_t model_hi;
    word_t model_lo;

    // command in flight, captured at acceptance
    logic      in_flight;
    op_t       pend_op;
    reg_addr_t pend_rd;
    addr_t     pend_addr;
    word_t     pend_alu;
    word_t     pend_store;
    word_t     pend_pc;

    int errors = 0;
    int checks = 0;

    mips_mem_wb mips_mem_wb_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected completion of one command on the current model state
    function automatic void expected_result(input op_t op, input addr_t addr, input word_t alu,
                                            input word_t pc, output logic exp_we,
                                            output logic exp_err, output word_t exp_data);
        word_t       mem_word;
        logic [7:0]  lane_b;
        logic [15:0] lane_h;
        mem_word = model_mem[addr[IDX_W+1:2]];
        lane_b   = mem_word[{addr[1:0], 3'b000} +: 8];
        lane_h   = mem_word[{addr[1], 4'b0000} +: 16];
        exp_we   = 1'b1;
        exp_err  = 1'b0;
        exp_data = alu;
        case (op)
            `OP_LW: begin
                exp_err  = (addr[1:0] != 2'b00);
                exp_data = mem_word;
            end
            `OP_LB:   exp_data = {{24{lane_b[7]}}, lane_b};
            `OP_LBU:  exp_data = {24'h000000, lane_b};
            `OP_LH: begin
                exp_err  = addr[0];
                exp_data = {{16{lane_h[15]}}, lane_h};
            end
            `OP_LHU: begin
                exp_err  = addr[0];
                exp_data = {16'h0000, lane_h};
            end
            `OP_SW:   exp_err = (addr[1:0] != 2'b00);
            `OP_SH:   exp_err = addr[0];
            `OP_LINK: exp_data = pc + 32'd4;
            `OP_MFHI: exp_data = model_hi;
            `OP_MFLO: exp_data = model_lo;
            default:  ;
        endcase
        if (exp_err || op inside {`OP_SW, `OP_SB, `OP_SH, `OP_MTHI, `OP_MTLO}) begin
            exp_we = 1'b0;
        end
    endfunction

    function automatic void update_model(input op_t op, input reg_addr_t rd, input addr_t addr,
                                         input word_t alu, input word_t store, input logic we,
                                         input logic bad, input word_t data);
        logic [IDX_W-1:0] idx;
        idx = addr[IDX_W+1:2];
        if (!bad) begin
            case (op)
                `OP_SW:   model_mem[idx] = store;
                `OP_SB:   model_mem[idx][{addr[1:0], 3'b000} +: 8] = store[7:0];
                `OP_SH:   model_mem[idx][{addr[1], 4'b0000} +: 16] = store[15:0];
                `OP_MTHI: model_hi = alu;
                `OP_MTLO: model_lo = alu;
                default:  ;
            endcase
        end
        if (we && rd != 5'd0) begin
            model_regs[rd] = data;
        end
    endfunction

    // comparator sampling at the falling edge
    initial begin
        logic  exp_we;
        logic  exp_err;
        word_t exp_data;
        in_flight = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (done) begin
                    checks++;
                    assert (in_flight) else begin
                        errors++;
                        $display("done pulsed with no command in flight");
                    end
                    expected_result(pend_op, pend_addr, pend_alu, pend_pc,
                                    exp_we, exp_err, exp_data);
                    assert (err === exp_err) else begin
                        errors++;
                        $display("FAIL err: got %h expected %h (op %h addr %h)",
                                 err, exp_err, pend_op, pend_addr);
                    end
                    assert (wb_we === exp_we) else begin
                        errors++;
                        $display("FAIL wb_we: got %h expected %h (op %h addr %h)",
                                 wb_we, exp_we, pend_op, pend_addr);
                    end
                    if (exp_we) begin
                        assert (wb_addr === pend_rd) else begin
                            errors++;
                            $display("FAIL wb_addr: got %h expected %h", wb_addr, pend_rd);
                        end
                        assert (wb_data === exp_data) else begin
                            errors++;
                            $display("FAIL wb_data: got %h expected %h (op %h addr %h)",
                                     wb_data, exp_data, pend_op, pend_addr);
                        end
                    end
                    update_model(pend_op, pend_rd, pend_addr, pend_alu, pend_store,
                                 exp_we, exp_err, exp_data);
                    in_flight = 1'b0;
                end else if (in_flight) begin
                    assert (!cmd_ready) else begin
                        errors++;
                        $display("cmd_ready went high while a command was in flight");
                    end
                end
                if (cmd_valid && cmd_ready) begin
                    pend_op    = cmd_op;
                    pend_rd    = cmd_rd;
                    pend_addr  = cmd_addr;
                    pend_alu   = cmd_alu_out;
                    pend_store = cmd_store_data;
                    pend_pc    = cmd_pc_plus4;
                    in_flight  = 1'b1;
                end
            end
        end
    end

    // holds cmd_valid until the command is taken, returns 1 ns after that edge
    task automatic send_cmd(input op_t op, input reg_addr_t rd, input addr_t addr,
                            input word_t alu, input word_t store, input word_t pc);
        cmd_valid      = 1'b1;
        cmd_op         = op;
        cmd_rd         = rd;
        cmd_addr       = addr;
        cmd_alu_out    = alu;
        cmd_store_data = store;
        cmd_pc_plus4   = pc;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic check_reg(input reg_addr_t r);
        wait_idle();
        rd_addr = r;
        @(negedge clk);
        checks++;
        assert (rd_data === model_regs[r]) else begin
            errors++;
            $display("FAIL rd_data (reg %0d): got %h expected %h", r, rd_data, model_regs[r]);
        end
        @(posedge clk);
        #1;
    endtask

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

    initial begin
        addr_t a;
        void'($urandom(32'h4b36));
        rst_n          = 1'b0;
        cmd_valid      = 1'b0;
        cmd_op         = '0;
        cmd_rd         = '0;
        cmd_addr       = '0;
        cmd_alu_out    = '0;
        cmd_store_data = '0;
        cmd_pc_plus4   = '0;
        rd_addr        = '0;
        model_hi       = '0;
        model_lo       = '0;
        for (int w = 0; w < `MIPS_MEM_WORDS; w++) begin
            model_mem[w] = '0;
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        checks++;
        assert (cmd_ready === 1'b1 && done === 1'b0 && err === 1'b0 && wb_we === 1'b0)
        else begin
            errors++;
            $display("FAIL reset state: cmd_ready %h done %h err %h wb_we %h",
                     cmd_ready, done, err, wb_we);
        end
        @(posedge clk);
        #1;

        // ALU results, register 0 and link
        for (int r = 1; r <= 5; r++) begin
            send_cmd(`OP_ALU, 5'(r), '0, $urandom, '0, '0);
        end
        send_cmd(`OP_ALU, 5'd0, '0, 32'hdead_beef, '0, '0);
        send_cmd(`OP_LINK, 5'd31, '0, '0, '0, 32'h0040_0010);
        check_reg(5'd1);
        check_reg(5'd0);
        check_reg(5'd31);

        // word store, then byte and halfword lanes over it
        send_cmd(`OP_SW, 5'd0, 32'h10, '0, 32'h1234_5678, '0);
        send_cmd(`OP_LW, 5'd8, 32'h10, '0, '0, '0);
        for (int off = 0; off < 4; off++) begin
            send_cmd(`OP_SB, 5'd0, 32'h10 + off, '0, $urandom, '0);
            send_cmd(`OP_LW, 5'd8, 32'h10, '0, '0, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            send_cmd(`OP_SH, 5'd0, 32'h10 + off, '0, $urandom, '0);
            send_cmd(`OP_LW, 5'd8, 32'h10, '0, '0, '0);
        end

        // random window of 16 words, every legal offset, then random loads
        for (int w = 0; w < 16; w++) begin
            send_cmd(`OP_SW, 5'd0, 32'h100 + 4 * w, '0, $urandom, '0);
        end
        for (int off = 0; off < 4; off++) begin
            send_cmd(`OP_LB, 5'd9, 32'h104 + off, '0, '0, '0);
            send_cmd(`OP_LBU, 5'd10, 32'h104 + off, '0, '0, '0);
            if (off % 2 == 0) begin
                send_cmd(`OP_LH, 5'd11, 32'h104 + off, '0, '0, '0);
                send_cmd(`OP_LHU, 5'd12, 32'h104 + off, '0, '0, '0);
            end
        end
        for (int i = 0; i < 40; i++) begin
            a = 32'h100 + $urandom_range(0, 63);
            case ($urandom_range(0, 4))
                0:       send_cmd(`OP_LB, 5'd9, a, '0, '0, '0);
                1:       send_cmd(`OP_LBU, 5'd10, a, '0, '0, '0);
                2:       send_cmd(`OP_LH, 5'd11, {a[31:1], 1'b0}, '0, '0, '0);
                3:       send_cmd(`OP_LHU, 5'd12, {a[31:1], 1'b0}, '0, '0, '0);
                default: send_cmd(`OP_LW, 5'd13, {a[31:2], 2'b00}, '0, '0, '0);
            endcase
        end

        // hi and lo
        send_cmd(`OP_MTHI, 5'd4, '0, $urandom, '0, '0);
        send_cmd(`OP_MTLO, 5'd5, '0, $urandom, '0, '0);
        send_cmd(`OP_MFHI, 5'd6, '0, '0, '0, '0);
        send_cmd(`OP_MFLO, 5'd7, '0, '0, '0, '0);
        check_reg(5'd6);
        check_reg(5'd7);

        // misaligned accesses are refused and change nothing
        send_cmd(`OP_LH, 5'd1, 32'h105, '0, '0, '0);
        send_cmd(`OP_LHU, 5'd2, 32'h107, '0, '0, '0);
        send_cmd(`OP_LW, 5'd3, 32'h10a, '0, '0, '0);
        send_cmd(`OP_SH, 5'd0, 32'h109, '0, $urandom, '0);
        send_cmd(`OP_SW, 5'd0, 32'h10f, '0, $urandom, '0);
        send_cmd(`OP_LW, 5'd13, 32'h108, '0, '0, '0);
        send_cmd(`OP_LW, 5'd14, 32'h10c, '0, '0, '0);
        check_reg(5'd1);
        check_reg(5'd2);
        check_reg(5'd3);

        wait_idle();
        errors += mips_mem_wb_inst.load_store_unit_inst.apb_checks_inst.fail_count;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
